// ==== sim.f ====
src/ex_isa_pkg.sv
src/ex_bus_pkg.sv
src/ex_alu.sv
src/ex_bru.sv
src/ex_eh.sv
src/ex_pipe_buf.sv
src/ex_pipe.sv
tests/ex_pipe_props.sv
tests/ex_pipe_tb.sv

// ==== tests/ex_pipe_tb.sv ====
// Testbench for the integer execution pipe with a reference model and result scoreboard
`timescale 1ns/1ns

module ex_pipe_tb;
   import ex_isa_pkg::*;
   import ex_bus_pkg::*;

   // Expected result and which fields carry meaning
   typedef struct packed {
      wb_t  wb;
      logic chk_wdata;
      logic chk_opera;
      logic chk_operb;
   } exp_t;

   localparam int     n_alu          = 200;
   localparam int     n_bru          = 8 * 12;
   localparam int     n_lsu          = 40;
   localparam int     n_flt          = 7 * 4;
   localparam int     n_bp           = 300;
   localparam int     total_ops      = n_alu + n_bru + n_lsu + n_flt + n_bp + 2;
   localparam int     timeout_cycles = total_ops * 20 + 200;
   localparam evect_t evect_base     = 32'hfff0_0000;

   logic   clk = 1'b0;
   logic   reset;
   logic   flush;
   logic   ex_valid;
   logic   ex_ready;
   logic   wb_valid;
   logic   wb_ready;
   logic   acc_prev;
   logic   bp_on;
   evect_t evect;
   issue_t ex_bus;
   wb_t    wb_bus;
   exp_t   exp_q[$];
   string  cur_test = "reset";
   int     errors = 0;
   int     test_errs = 0;
   int     tests_ok = 0;
   int     tests_bad = 0;
   int     n_results = 0;

   ex_pipe #(
      .enable_mul (1'b1)
   ) ex_pipe_i (
      .clk        (clk),
      .reset      (reset),
      .flush      (flush),
      .evect      (evect),
      .ex_valid   (ex_valid),
      .ex_bus     (ex_bus),
      .ex_ready   (ex_ready),
      .wb_valid   (wb_valid),
      .wb_bus     (wb_bus),
      .wb_ready   (wb_ready)
   );

   always #5 clk = ~clk;

   // Random stalls from writeback when enabled
   always @(posedge clk) begin
      wb_ready <= bp_on ? 1'($urandom % 2) : 1'b1;
   end

   function automatic logic bru_taken(issue_t op);
      case (op.bru_op)
         bru_beq:  return op.op1 == op.op2;
         bru_bne:  return op.op1 != op.op2;
         bru_blt:  return $signed(op.op1) < $signed(op.op2);
         bru_bltu: return op.op1 < op.op2;
         bru_bge:  return $signed(op.op1) >= $signed(op.op2);
         bru_bgeu: return op.op1 >= op.op2;
         default:  return 1'b1;
      endcase
   endfunction

   function automatic pc_t bru_target(issue_t op);
      return (op.bru_op == bru_jalr) ? op.op1[31:0] + op.imm[31:0] : op.pc + op.imm[31:0];
   endfunction

   function automatic data_t alu_ref(issue_t op);
      case (op.alu_op)
         alu_add:  return op.op1 + op.op2;
         alu_sub:  return op.op1 - op.op2;
         alu_and:  return op.op1 & op.op2;
         alu_or:   return op.op1 | op.op2;
         alu_xor:  return op.op1 ^ op.op2;
         alu_sll:  return op.op1 << op.op2[5:0];
         alu_srl:  return op.op1 >> op.op2[5:0];
         alu_sra:  return $signed(op.op1) >>> op.op2[5:0];
         alu_slt:  return data_t'($signed(op.op1) < $signed(op.op2));
         alu_sltu: return data_t'(op.op1 < op.op2);
         default:  return op.op1 * op.op2;
      endcase
   endfunction

   function automatic exp_t model_op(issue_t op);
      exp_t e;
      pc_t  npc;
      logic tk;
      e = '0;
      npc = op.pc + 32'd1;
      tk = bru_taken(op);
      e.wb.rob_id = op.rob_id;
      e.wb.prf_waddr = op.prd;
      case (op.fu)
         fu_alu: begin
            e.wb.prf_we = op.prd_we;
            e.wb.prf_wdata = alu_ref(op);
            e.chk_wdata = 1'b1;
         end
         fu_bru: begin
            if (op.bru_op inside {bru_jal, bru_jalr}) begin
               e.wb.prf_we = op.prd_we;
               e.wb.prf_wdata = data_t'(npc);
               e.chk_wdata = 1'b1;
            end
            // Wrong direction or taken to the wrong place
            e.wb.fls = (tk != op.pred_taken) || (tk && bru_target(op) != op.pred_tgt);
            e.wb.fls_tgt = tk ? bru_target(op) : npc;
         end
         default: begin
            e.wb.opera = op.op1 + op.imm;
            e.wb.operb = op.op2;
            e.chk_opera = 1'b1;
            e.chk_operb = 1'b1;
         end
      endcase
      // Fetch faults beat a mispredict and the lowest flag bit wins
      if (op.fe != 3'b000) begin
         e.wb.fls = 1'b1;
         e.wb.fls_tgt = evect + (op.fe[0] ? vec_off_itm : op.fe[1] ? vec_off_ipf : vec_off_syscall);
         e.wb.prf_we = 1'b0;
         e.chk_wdata = 1'b0;
      end
      if (e.wb.fls) begin
         e.wb.opera = data_t'(e.wb.fls_tgt);
         e.chk_opera = 1'b1;
      end
      return e;
   endfunction

   task automatic check_val(string field, logic [63:0] exp_v, logic [63:0] act_v);
      assert (exp_v === act_v) else begin
         $display("[FAIL] %s %s expected %h actual %h", cur_test, field, exp_v, act_v);
         errors++;
      end
   endtask

   task automatic report_error(string what);
      $display("ERROR in %s: %s", cur_test, what);
      errors++;
   endtask

   task automatic compare(exp_t e);
      check_val("rob_id", 64'(e.wb.rob_id), 64'(wb_bus.rob_id));
      check_val("prf_waddr", 64'(e.wb.prf_waddr), 64'(wb_bus.prf_waddr));
      check_val("prf_we", 64'(e.wb.prf_we), 64'(wb_bus.prf_we));
      check_val("fls", 64'(e.wb.fls), 64'(wb_bus.fls));
      if (e.chk_wdata) check_val("prf_wdata", e.wb.prf_wdata, wb_bus.prf_wdata);
      if (e.wb.fls) check_val("fls_tgt", 64'(e.wb.fls_tgt), 64'(wb_bus.fls_tgt));
      if (e.chk_opera) check_val("opera", e.wb.opera, wb_bus.opera);
      if (e.chk_operb) check_val("operb", e.wb.operb, wb_bus.operb);
   endtask

   // Scoreboard samples the pre-edge values
   always @(posedge clk) begin
      if (reset || flush) begin
         exp_q.delete();
         acc_prev = 1'b0;
      end else begin
         assert (!acc_prev || wb_valid) else report_error("no result one cycle after issue");
         assert (ex_ready == (!wb_valid || wb_ready)) else report_error("ex_ready out of step");
         if (wb_valid && wb_ready) begin
            n_results++;
            assert (exp_q.size() > 0) else report_error("result without a matching issue");
            if (exp_q.size() > 0) compare(exp_q.pop_front());
         end
         acc_prev = ex_valid && ex_ready;
         if (acc_prev) exp_q.push_back(model_op(ex_bus));
      end
   end

   function automatic issue_t rand_op(fu_e fu);
      issue_t op;
      op = '0;
      op.fu = fu;
      op.alu_op = alu_op_e'($urandom % 11);
      op.bru_op = bru_op_e'($urandom % 8);
      op.pc = $urandom;
      op.imm = 64'($signed(16'($urandom)));
      op.op1 = {$urandom, $urandom};
      // Equal operands now and then for the compares
      op.op2 = ($urandom % 4 == 0) ? op.op1 : {$urandom, $urandom};
      op.pred_taken = 1'($urandom % 2);
      op.pred_tgt = $urandom;
      op.prd = 6'($urandom);
      op.prd_we = ($urandom % 8 != 0);
      op.rob_id = 5'($urandom);
      return op;
   endfunction

   task automatic issue_op(issue_t op);
      ex_valid <= 1'b1;
      ex_bus <= op;
      @(posedge clk);
      while (!ex_ready) @(posedge clk);
      ex_valid <= 1'b0;
   endtask

   task automatic drain();
      bp_on <= 1'b0;
      @(negedge clk);
      while (exp_q.size() != 0 || wb_valid) @(negedge clk);
      @(posedge clk);
   endtask

   task automatic end_test();
      drain();
      if (errors == test_errs) begin
         tests_ok++;
         $display("%s: ok", cur_test);
      end else begin
         tests_bad++;
         $display("%s: %0d errors", cur_test, errors - test_errs);
      end
      test_errs = errors;
   endtask

   initial begin
      issue_t op;
      logic   tk;
      int     start_results;
      void'($urandom(43509));
      reset = 1'b1;
      flush = 1'b0;
      ex_valid = 1'b0;
      ex_bus = '0;
      evect = evect_base;
      wb_ready = 1'b1;
      bp_on = 1'b0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);

      cur_test = "alu_random";
      repeat (n_alu) issue_op(rand_op(fu_alu));
      end_test();

      cur_test = "bru_predict";
      for (int b = 0; b < 8; b++) begin
         for (int k = 0; k < 12; k++) begin
            op = rand_op(fu_bru);
            op.bru_op = bru_op_e'(b);
            tk = bru_taken(op);
            case (k % 4)
               0: op.pred_taken = tk;
               1: begin
                  op.pred_taken = !tk;
                  op.pred_tgt = bru_target(op);
               end
               2: begin
                  op.pred_taken = tk;
                  op.pred_tgt = bru_target(op) + 32'd7;
               end
               default: op.pred_taken = 1'b1;
            endcase
            // Right direction needs the right target too
            if (k % 4 == 0 && tk) op.pred_tgt = bru_target(op);
            issue_op(op);
         end
      end
      end_test();

      cur_test = "lsu_addr";
      repeat (n_lsu) issue_op(rand_op(fu_lsu));
      end_test();

      cur_test = "fault_priority";
      for (int f = 1; f < 8; f++) begin
         repeat (4) begin
            op = rand_op(fu_bru);
            op.fe = fe_t'(f);
            op.pred_taken = !bru_taken(op);
            op.pred_tgt = bru_target(op);
            issue_op(op);
         end
      end
      end_test();

      cur_test = "backpressure";
      bp_on <= 1'b1;
      repeat (n_bp) begin
         issue_op(rand_op(fu_e'($urandom % 3)));
         if ($urandom % 4 == 0) @(posedge clk);
      end
      end_test();

      cur_test = "flush_drop";
      start_results = n_results;
      issue_op(rand_op(fu_alu));
      // Second op offered while the first sits in the stage
      ex_valid <= 1'b1;
      ex_bus <= rand_op(fu_alu);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      ex_valid <= 1'b0;
      @(negedge clk);
      assert (!wb_valid) else report_error("stage still valid after flush");
      @(posedge clk);
      issue_op(rand_op(fu_alu));
      drain();
      assert (n_results == start_results + 1) else report_error("flushed ops came back");
      end_test();

      $display("tests passed: %0d, tests failed: %0d, property failures: %0d",
               tests_ok, tests_bad, ex_pipe_i.u_props.fail_count);
      if (errors == 0 && tests_bad == 0 && ex_pipe_i.u_props.fail_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // Hang guard sized from the number of issued ops
   initial begin
      #(timeout_cycles * 10);
      $display("Timeout in %s: no finish after %0d cycles", cur_test, timeout_cycles);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== tests/ex_pipe_props.sv ====
// Bound assertions on the writeback handshake, reset state and flush of the execution pipe
`timescale 1ns/1ns

module ex_pipe_props (
   input logic            clk,
   input logic            reset,
   input logic            flush,
   input logic            wb_valid,
   input logic            wb_ready,
   input ex_bus_pkg::wb_t wb_bus
);

   int fail_count = 0;

   // Stage leaves reset empty with both strobes clear
   a_reset_empty: assert property (@(posedge clk)
      reset |=> (!wb_valid && !wb_bus.prf_we && !wb_bus.fls))
   else begin
      fail_count++;
      $error("writeback stage not empty after reset");
   end

   // Held result must not move under back-pressure
   a_hold: assert property (@(posedge clk) disable iff (reset)
      (wb_valid && !wb_ready && !flush) |=> (wb_valid && $stable(wb_bus)))
   else begin
      fail_count++;
      $error("wb_bus changed while stalled");
   end

   a_flush_empty: assert property (@(posedge clk) disable iff (reset)
      flush |=> !wb_valid)
   else begin
      fail_count++;
      $error("wb_valid high the cycle after flush");
   end

   // A register write only shows up with a valid result
   a_we_valid: assert property (@(posedge clk) disable iff (reset)
      wb_bus.prf_we |-> wb_valid)
   else begin
      fail_count++;
      $error("prf_we high without wb_valid");
   end

endmodule

bind ex_pipe ex_pipe_props u_props (
   .clk      (clk),
   .reset    (reset),
   .flush    (flush),
   .wb_valid (wb_valid),
   .wb_ready (wb_ready),
   .wb_bus   (wb_bus)
);

// ==== src/ex_pipe.sv ====
// Integer execution pipe: ALU, branch check, address generation and the writeback stage
`timescale 1ns/1ns

module ex_pipe #(
   parameter bit enable_mul = 1'b1
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               flush,
   input  ex_isa_pkg::evect_t evect,
   // From the reservation station
   input  logic               ex_valid,
   input  ex_bus_pkg::issue_t ex_bus,
   output logic               ex_ready,
   // To writeback
   output logic               wb_valid,
   output ex_bus_pkg::wb_t    wb_bus,
   input  logic               wb_ready
);
   import ex_isa_pkg::*;
   import ex_bus_pkg::*;

   logic  is_alu;
   logic  is_bru;
   logic  is_lsu;
   logic  agu_en;
   logic  add_s;
   data_t add_b;
   data_t add_bx;
   data_t add_sum;
   logic  add_carry;
   logic  add_overflow;
   pc_t   npc;
   data_t alu_result;
   logic  alu_illegal;
   logic  b_taken;
   pc_t   b_tgt;
   data_t b_link;
   logic  b_link_we;
   logic  exc;
   pc_t   exc_tgt;
   logic  se_fail;
   pc_t   se_tgt;
   logic  s1_fls;
   pc_t   s1_fls_tgt;
   logic  s1_rf_we;
   wb_t   s1_wb;
   logic  load;

   assign is_alu = (ex_bus.fu == fu_alu);
   assign is_bru = (ex_bus.fu == fu_bru);
   assign is_lsu = (ex_bus.fu == fu_lsu);

   // Shared adder also serves as the LSU address generator
   assign agu_en = is_lsu;
   assign add_s  = (is_alu & (ex_bus.alu_op inside {alu_sub, alu_slt, alu_sltu})) |
                   (is_bru & ~(ex_bus.bru_op inside {bru_jal, bru_jalr}));
   assign add_b  = agu_en ? ex_bus.imm : ex_bus.op2;
   assign add_bx = add_s ? ~add_b : add_b;
   assign {add_carry, add_sum} = {1'b0, ex_bus.op1} + {1'b0, add_bx} + 65'(add_s);
   assign add_overflow = (ex_bus.op1[63] == add_bx[63]) & (add_sum[63] != ex_bus.op1[63]);

   assign npc = ex_bus.pc + pc_t'(1);

   ex_alu #(
      .enable_mul   (enable_mul)
   ) u_alu (
      .alu_op       (ex_bus.alu_op),
      .op1          (ex_bus.op1),
      .op2          (ex_bus.op2),
      .add_sum      (add_sum),
      .add_carry    (add_carry),
      .add_overflow (add_overflow),
      .result       (alu_result),
      .illegal      (alu_illegal)
   );

   ex_bru u_bru (
      .bru_op       (ex_bus.bru_op),
      .pc           (ex_bus.pc),
      .npc          (npc),
      .imm          (ex_bus.imm),
      .op1          (ex_bus.op1),
      .add_sum      (add_sum),
      .add_carry    (add_carry),
      .add_overflow (add_overflow),
      .taken        (b_taken),
      .tgt          (b_tgt),
      .link         (b_link),
      .link_we      (b_link_we)
   );

   ex_eh u_eh (
      .fe           (ex_bus.fe),
      .illegal      (is_alu & alu_illegal),
      .evect        (evect),
      .exc          (exc),
      .exc_tgt      (exc_tgt)
   );

   // Speculation check where the target only matters when taken
   assign se_fail = is_bru &
                    ((b_taken ^ ex_bus.pred_taken) | (b_taken & (b_tgt != ex_bus.pred_tgt)));
   assign se_tgt  = b_taken ? b_tgt : npc;

   // Exception outranks a mispredict
   assign s1_fls     = exc | se_fail;
   assign s1_fls_tgt = exc ? exc_tgt : se_tgt;

   // LSU results wait for commit, so no register write here
   assign s1_rf_we = ~exc & ex_bus.prd_we & (is_alu | (is_bru & b_link_we));

   always_comb begin
      s1_wb.rob_id    = ex_bus.rob_id;
      s1_wb.prf_we    = s1_rf_we;
      s1_wb.prf_waddr = ex_bus.prd;
      s1_wb.prf_wdata = is_bru ? b_link : alu_result;
      s1_wb.fls       = s1_fls;
      s1_wb.fls_tgt   = s1_fls_tgt;
      if (s1_fls) begin
         s1_wb.opera = data_t'(s1_fls_tgt);
      end else if (is_lsu) begin
         s1_wb.opera = add_sum;
      end else begin
         s1_wb.opera = '0;
      end
      s1_wb.operb     = ex_bus.op2;
   end

   ex_pipe_buf u_buf (
      .clk          (clk),
      .reset        (reset),
      .flush        (flush),
      .a_valid      (ex_valid),
      .a_ready      (ex_ready),
      .b_valid      (wb_valid),
      .b_ready      (wb_ready),
      .load         (load)
   );

   // Writeback register where only the write and flush strobes get cleared
   always_ff @(posedge clk) begin
      if (reset | flush) begin
         wb_bus.prf_we <= 1'b0;
         wb_bus.fls    <= 1'b0;
      end else if (load) begin
         wb_bus <= s1_wb;
      end else if (wb_valid & wb_ready) begin
         // Result has left and nothing replaces it
         wb_bus.prf_we <= 1'b0;
         wb_bus.fls    <= 1'b0;
      end
   end

endmodule

// ==== src/ex_pipe_buf.sv ====
// Single-entry pipeline stage control with ready bypass and flush
`timescale 1ns/1ns

module ex_pipe_buf (
   input  logic clk,
   input  logic reset,
   input  logic flush,
   input  logic a_valid,
   output logic a_ready,
   output logic b_valid,
   input  logic b_ready,
   output logic load
);

   logic valid_q;

   // Accept when empty or when the held item leaves this cycle
   assign a_ready = ~valid_q | b_ready;

   // Issue offered alongside a flush is dropped
   assign load = a_valid & a_ready & ~flush;

   assign b_valid = valid_q;

   always_ff @(posedge clk) begin
      if (reset | flush) begin
         valid_q <= 1'b0;
      end else if (a_ready) begin
         // Refill or drain
         valid_q <= a_valid;
      end
   end

endmodule

// ==== src/ex_eh.sv ====
// Exception prioritizer: picks the highest-priority cause and forms its vector address
`timescale 1ns/1ns

module ex_eh (
   input  ex_isa_pkg::fe_t    fe,
   input  logic               illegal,
   input  ex_isa_pkg::evect_t evect,
   output logic               exc,
   output ex_isa_pkg::pc_t    exc_tgt
);
   import ex_isa_pkg::*;

   evect_t vec_off;

   assign exc = (|fe) | illegal;

   // Priority itm > ipf > syscall > illegal
   always_comb begin
      if (fe[fe_itm]) begin
         vec_off = vec_off_itm;
      end else if (fe[fe_ipf]) begin
         vec_off = vec_off_ipf;
      end else if (fe[fe_syscall]) begin
         vec_off = vec_off_syscall;
      end else begin
         vec_off = vec_off_illegal;
      end
   end

   assign exc_tgt = pc_t'(evect + vec_off);

endmodule

// ==== src/ex_bru.sv ====
// Branch resolution unit: taken, target and link value from the shared subtractor flags
`timescale 1ns/1ns

module ex_bru (
   input  ex_isa_pkg::bru_op_e bru_op,
   input  ex_isa_pkg::pc_t     pc,
   input  ex_isa_pkg::pc_t     npc,
   input  ex_isa_pkg::data_t   imm,
   input  ex_isa_pkg::data_t   op1,
   input  ex_isa_pkg::data_t   add_sum,
   input  logic                add_carry,
   input  logic                add_overflow,
   output logic                taken,
   output ex_isa_pkg::pc_t     tgt,
   output ex_isa_pkg::data_t   link,
   output logic                link_we
);
   import ex_isa_pkg::*;

   logic is_eq;
   logic is_lt;
   logic is_ltu;
   logic is_jump;
   pc_t  rel_tgt;
   pc_t  reg_tgt;

   // Compare flags, adder holds op1 - op2
   assign is_eq  = (add_sum == '0);
   assign is_lt  = add_sum[63] ^ add_overflow;
   assign is_ltu = ~add_carry;

   assign is_jump = (bru_op == bru_jal) | (bru_op == bru_jalr);

   always_comb begin
      case (bru_op)
         bru_beq: begin
            taken = is_eq;
         end
         bru_bne: begin
            taken = ~is_eq;
         end
         bru_blt: begin
            taken = is_lt;
         end
         bru_bltu: begin
            taken = is_ltu;
         end
         bru_bge: begin
            taken = ~is_lt;
         end
         bru_bgeu: begin
            taken = ~is_ltu;
         end
         // Unconditional jumps
         default: begin
            taken = 1'b1;
         end
      endcase
   end

   // PC-relative for branches and jal, register-based for jalr
   assign rel_tgt = pc + pc_t'(imm);
   assign reg_tgt = pc_t'(op1) + pc_t'(imm);
   assign tgt     = (bru_op == bru_jalr) ? reg_tgt : rel_tgt;

   // Return address, written only by jumps
   assign link    = data_t'(npc);
   assign link_we = is_jump;

endmodule

// ==== src/ex_alu.sv ====
// Integer ALU with optional multiplier, add and subtract taken from the shared adder
`timescale 1ns/1ns

module ex_alu #(
   parameter bit enable_mul = 1'b1
) (
   input  ex_isa_pkg::alu_op_e alu_op,
   input  ex_isa_pkg::data_t   op1,
   input  ex_isa_pkg::data_t   op2,
   input  ex_isa_pkg::data_t   add_sum,
   input  logic                add_carry,
   input  logic                add_overflow,
   output ex_isa_pkg::data_t   result,
   output logic                illegal
);
   import ex_isa_pkg::*;

   logic [5:0] shamt;
   logic       lt_signed;
   logic       lt_unsigned;
   data_t      mul_res;

   assign shamt = op2[5:0];

   // Adder runs op1 - op2 for slt and sltu
   assign lt_signed   = add_sum[63] ^ add_overflow;
   assign lt_unsigned = ~add_carry;

   generate
      if (enable_mul) begin : g_mul
         // Low half of the product
         assign mul_res = op1 * op2;
      end else begin : g_no_mul
         assign mul_res = '0;
      end
   endgenerate

   // Without a multiplier, mul is an illegal instruction
   assign illegal = (alu_op == alu_mul) & ~enable_mul;

   always_comb begin
      case (alu_op)
         alu_add,
         alu_sub: begin
            result = add_sum;
         end
         alu_and: begin
            result = op1 & op2;
         end
         alu_or: begin
            result = op1 | op2;
         end
         alu_xor: begin
            result = op1 ^ op2;
         end
         alu_sll: begin
            result = op1 << shamt;
         end
         alu_srl: begin
            result = op1 >> shamt;
         end
         alu_sra: begin
            result = data_t'($signed(op1) >>> shamt);
         end
         alu_slt: begin
            result = data_t'(lt_signed);
         end
         alu_sltu: begin
            result = data_t'(lt_unsigned);
         end
         alu_mul: begin
            result = mul_res;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

// ==== src/ex_bus_pkg.sv ====
// Issue and writeback bus structures for the integer execution pipe
package ex_bus_pkg;

   // One issued micro-op with its operands
   typedef struct packed {
      ex_isa_pkg::fu_e     fu;
      ex_isa_pkg::alu_op_e alu_op;
      ex_isa_pkg::bru_op_e bru_op;
      ex_isa_pkg::fe_t     fe;
      // Front-end prediction
      logic                pred_taken;
      ex_isa_pkg::pc_t     pred_tgt;
      ex_isa_pkg::pc_t     pc;
      ex_isa_pkg::data_t   imm;
      ex_isa_pkg::data_t   op1;
      ex_isa_pkg::data_t   op2;
      // Destination physical register
      ex_isa_pkg::preg_t   prd;
      logic                prd_we;
      ex_isa_pkg::rob_id_t rob_id;
   } issue_t;

   // Result handed to writeback
   typedef struct packed {
      ex_isa_pkg::rob_id_t rob_id;
      logic                prf_we;
      ex_isa_pkg::preg_t   prf_waddr;
      ex_isa_pkg::data_t   prf_wdata;
      // Flush request and its redirect target
      logic                fls;
      ex_isa_pkg::pc_t     fls_tgt;
      // LSU address or flush target, then store data
      ex_isa_pkg::data_t   opera;
      ex_isa_pkg::data_t   operb;
   } wb_t;

endpackage

// ==== src/ex_isa_pkg.sv ====
// Integer pipe ISA definitions: widths, opcodes, fetch faults and vector offsets
package ex_isa_pkg;

   // Datapath widths
   typedef logic [63:0] data_t;
   // Word-addressed, so the next PC is pc + 1
   typedef logic [31:0] pc_t;
   typedef logic [5:0]  preg_t;
   typedef logic [4:0]  rob_id_t;
   typedef logic [31:0] evect_t;

   // Function-unit class of an issued micro-op
   typedef enum logic [1:0] {
      fu_alu = 2'd0,
      fu_bru = 2'd1,
      fu_lsu = 2'd2
   } fu_e;

   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_and  = 4'd2,
      alu_or   = 4'd3,
      alu_xor  = 4'd4,
      alu_sll  = 4'd5,
      alu_srl  = 4'd6,
      alu_sra  = 4'd7,
      alu_slt  = 4'd8,
      alu_sltu = 4'd9,
      alu_mul  = 4'd10
   } alu_op_e;

   typedef enum logic [2:0] {
      bru_beq  = 3'd0,
      bru_bne  = 3'd1,
      bru_blt  = 3'd2,
      bru_bltu = 3'd3,
      bru_bge  = 3'd4,
      bru_bgeu = 3'd5,
      bru_jal  = 3'd6,
      bru_jalr = 3'd7
   } bru_op_e;

   // Fetch-side exception flags, one bit per cause
   typedef logic [2:0] fe_t;
   localparam int fe_itm     = 0;
   localparam int fe_ipf     = 1;
   localparam int fe_syscall = 2;

   // Offsets from the exception vector base
   localparam evect_t vec_off_itm     = 32'd1;
   localparam evect_t vec_off_ipf     = 32'd2;
   localparam evect_t vec_off_syscall = 32'd3;
   localparam evect_t vec_off_illegal = 32'd4;

endpackage
